// File: common/matmul_pkg.sv
package matmul_pkg;

    // ========================================================================
    // Data widths
    // ========================================================================

    // MMIO word, also used for DMA byte addresses
    typedef logic [31:0] word_t;

    // One DMA beat: four k-steps of four int8 lanes each
    typedef logic [127:0] block_t;

    typedef logic signed [7:0] elem_t;
    typedef logic signed [31:0] acc_t;

    // Valid rows or columns of the result tile, 1..4
    typedef logic [2:0] dim_t;

    // Valid k-steps inside one block, 1..4
    typedef logic [2:0] kcnt_t;

    // ========================================================================
    // Geometry and register map
    // ========================================================================

    localparam int TILE = 4;
    localparam word_t BLOCK_BYTES = 32'd16;

    // CTRL on write, STATUS on read
    localparam logic [7:0] REG_CTRL = 8'h00;
    localparam logic [7:0] REG_W_ADDR = 8'h04;
    localparam logic [7:0] REG_X_ADDR = 8'h08;
    localparam logic [7:0] REG_M_DIM = 8'h0C;
    localparam logic [7:0] REG_N_DIM = 8'h10;
    localparam logic [7:0] REG_K_DIM = 8'h14;
    // 16 result words, row-major, up to 0x54
    localparam logic [7:0] REG_RESULT_BASE = 8'h18;

    // ========================================================================
    // Block fetcher FSM
    // ========================================================================

    typedef enum logic [1:0] {
        F_IDLE,
        F_WAIT_A,
        F_WAIT_B,
        F_HAND
    } fetch_state_t;

endpackage

// File: verilog/mmio_regs.sv
`timescale 1ns/1ps

module mmio_regs (
    input  logic                clk,
    input  logic                reset,
    input  matmul_pkg::word_t   mmio_addr,
    input  matmul_pkg::word_t   mmio_wdata,
    input  logic [3:0]          mmio_we,
    input  logic                mmio_re,
    output matmul_pkg::word_t   mmio_rdata,
    input  logic                cmd_done,
    input  matmul_pkg::acc_t [matmul_pkg::TILE*matmul_pkg::TILE-1:0] results,
    output logic                start,
    output matmul_pkg::word_t   w_addr,
    output matmul_pkg::word_t   x_addr,
    output matmul_pkg::dim_t    m_dim,
    output matmul_pkg::dim_t    n_dim,
    output matmul_pkg::word_t   k_dim,
    output logic                busy
);
    import matmul_pkg::*;

    logic       wr;
    logic [7:0] wr_offset;
    logic       ctrl_wr;
    logic       start_req;
    logic       start_ok;
    logic       error;
    logic [7:0] rd_offset;
    logic [7:0] res_rel;

    // M and N beyond the tile edge saturate at 4
    function automatic dim_t clamp_dim(input word_t v);
        if (v > word_t'(TILE)) begin
            return dim_t'(TILE);
        end
        return v[2:0];
    endfunction

    assign wr        = |mmio_we;
    assign wr_offset = mmio_addr[7:0];
    assign ctrl_wr   = wr && (wr_offset == REG_CTRL);
    assign start_req = ctrl_wr && mmio_wdata[0];

    // Only one command in flight, and K of zero has nothing to run
    assign start_ok  = start_req && !busy && (k_dim != '0);

    // ========================================================================
    // Configuration registers
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            w_addr <= '0;
            x_addr <= '0;
            m_dim  <= '0;
            n_dim  <= '0;
            k_dim  <= '0;
        end else if (wr) begin
            case (wr_offset)
                REG_W_ADDR: w_addr <= mmio_wdata;
                REG_X_ADDR: x_addr <= mmio_wdata;
                REG_M_DIM:  m_dim  <= clamp_dim(mmio_wdata);
                REG_N_DIM:  n_dim  <= clamp_dim(mmio_wdata);
                REG_K_DIM:  k_dim  <= mmio_wdata;
                default: ;
            endcase
        end
    end

    // ========================================================================
    // Start, busy and sticky error
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
            busy  <= 1'b0;
            error <= 1'b0;
        end else begin
            start <= start_ok;

            if (start_ok) begin
                busy <= 1'b1;
            end else if (cmd_done) begin
                busy <= 1'b0;
            end

            // A rejected start in the same write wins over the clear
            if (ctrl_wr && mmio_wdata[4]) begin
                error <= 1'b0;
            end
            if (start_req && !start_ok) begin
                error <= 1'b1;
            end
        end
    end

    // ========================================================================
    // Read path
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_offset <= '0;
        end else if (mmio_re) begin
            rd_offset <= mmio_addr[7:0];
        end
    end

    // Offsets below the result window wrap to large values here
    assign res_rel = rd_offset - REG_RESULT_BASE;

    always_comb begin
        if (rd_offset == REG_CTRL) begin
            mmio_rdata = {27'd0, error, 2'b00, !busy, busy};
        end else if ((res_rel < 8'd64) && (res_rel[1:0] == 2'b00)) begin
            mmio_rdata = word_t'(results[res_rel[5:2]]);
        end else begin
            mmio_rdata = '0;
        end
    end

endmodule

// File: fetch/block_fetch.sv
`timescale 1ns/1ps

module block_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  matmul_pkg::word_t   w_addr,
    input  matmul_pkg::word_t   x_addr,
    input  matmul_pkg::word_t   k_dim,
    output matmul_pkg::word_t   dma_addr,
    output logic                dma_re,
    input  matmul_pkg::block_t  dma_rdata,
    output logic                blk_req,
    output matmul_pkg::block_t  blk_a,
    output matmul_pkg::block_t  blk_b,
    output matmul_pkg::kcnt_t   blk_steps,
    output logic                blk_last,
    input  logic                blk_ack
);
    import matmul_pkg::*;

    fetch_state_t state;
    logic         resp_valid;
    word_t        a_addr;
    word_t        b_addr;
    word_t        blk_cnt;
    kcnt_t        last_steps;
    logic         a_done;
    logic         b_done;
    logic         hand_done;

    assign a_done    = (state == F_WAIT_A) && resp_valid;
    assign b_done    = (state == F_WAIT_B) && resp_valid;
    // Four-phase cycle is over once both req and ack are back low
    assign hand_done = (state == F_HAND) && !blk_req && !blk_ack;

    // ========================================================================
    // Sequencer
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= F_IDLE;
            dma_re     <= 1'b0;
            resp_valid <= 1'b0;
            blk_req    <= 1'b0;
        end else begin
            dma_re     <= 1'b0;
            // DMA answers exactly one cycle after the request
            resp_valid <= dma_re;

            case (state)
                F_IDLE: begin
                    if (start) begin
                        dma_re <= 1'b1;
                        state  <= F_WAIT_A;
                    end
                end
                F_WAIT_A: begin
                    if (resp_valid) begin
                        dma_re <= 1'b1;
                        state  <= F_WAIT_B;
                    end
                end
                F_WAIT_B: begin
                    if (resp_valid) begin
                        blk_req <= 1'b1;
                        state   <= F_HAND;
                    end
                end
                F_HAND: begin
                    if (blk_req) begin
                        if (blk_ack) begin
                            blk_req <= 1'b0;
                        end
                    end else if (!blk_ack) begin
                        if (blk_last) begin
                            state <= F_IDLE;
                        end else begin
                            dma_re <= 1'b1;
                            state  <= F_WAIT_A;
                        end
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // ========================================================================
    // Addresses, block count and the held block pair
    // ========================================================================

    always_ff @(posedge clk) begin
        if ((state == F_IDLE) && start) begin
            dma_addr   <= x_addr;
            a_addr     <= x_addr + BLOCK_BYTES;
            b_addr     <= w_addr;
            // ceil(K / 4)
            blk_cnt    <= {2'b00, k_dim[31:2]} + word_t'(|k_dim[1:0]);
            last_steps <= (k_dim[1:0] == 2'b00) ? kcnt_t'(TILE) : kcnt_t'(k_dim[1:0]);
        end
        if (a_done) begin
            blk_a    <= dma_rdata;
            dma_addr <= b_addr;
            b_addr   <= b_addr + BLOCK_BYTES;
        end
        if (b_done) begin
            blk_b     <= dma_rdata;
            blk_last  <= (blk_cnt == 32'd1);
            blk_steps <= (blk_cnt == 32'd1) ? last_steps : kcnt_t'(TILE);
            blk_cnt   <= blk_cnt - 32'd1;
        end
        if (hand_done && !blk_last) begin
            dma_addr <= a_addr;
            a_addr   <= a_addr + BLOCK_BYTES;
        end
    end

endmodule

// File: mac/mac_array.sv
`timescale 1ns/1ps

module mac_array (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  matmul_pkg::dim_t    m_dim,
    input  matmul_pkg::dim_t    n_dim,
    input  logic                blk_req,
    input  matmul_pkg::block_t  blk_a,
    input  matmul_pkg::block_t  blk_b,
    input  matmul_pkg::kcnt_t   blk_steps,
    input  logic                blk_last,
    output logic                blk_ack,
    output logic                cmd_done,
    output matmul_pkg::acc_t [matmul_pkg::TILE*matmul_pkg::TILE-1:0] results
);
    import matmul_pkg::*;

    dim_t                 m_lim;
    dim_t                 n_lim;
    acc_t [TILE*TILE-1:0] blk_sum;
    logic                 take;

    // New request seen, not yet acknowledged
    assign take = blk_req && !blk_ack;

    // ========================================================================
    // Sum of the outer products of one block
    // ========================================================================

    always_comb begin
        elem_t              a_e;
        elem_t              b_e;
        logic signed [15:0] prod;

        blk_sum = '0;
        for (int i = 0; i < TILE; i++) begin
            for (int j = 0; j < TILE; j++) begin
                for (int s = 0; s < TILE; s++) begin
                    // Step s, lane i of A and lane j of B
                    a_e  = elem_t'(blk_a[(s*TILE + i)*8 +: 8]);
                    b_e  = elem_t'(blk_b[(s*TILE + j)*8 +: 8]);
                    prod = a_e * b_e;
                    if (s < blk_steps) begin
                        blk_sum[i*TILE + j] = blk_sum[i*TILE + j] + prod;
                    end
                end
            end
        end
    end

    // Tile shape is held for the whole command
    always_ff @(posedge clk) begin
        if (start) begin
            m_lim <= m_dim;
            n_lim <= n_dim;
        end
    end

    // ========================================================================
    // Accumulators and handshake
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            blk_ack  <= 1'b0;
            cmd_done <= 1'b0;
            results  <= '0;
        end else begin
            cmd_done <= 1'b0;
            if (start) begin
                results <= '0;
            end else if (take) begin
                for (int i = 0; i < TILE; i++) begin
                    for (int j = 0; j < TILE; j++) begin
                        // Cells outside M x N never move off zero
                        if ((i < m_lim) && (j < n_lim)) begin
                            results[i*TILE + j] <= results[i*TILE + j] + blk_sum[i*TILE + j];
                        end
                    end
                end
                blk_ack  <= 1'b1;
                cmd_done <= blk_last;
            end else if (!blk_req) begin
                blk_ack <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/matmul_accel.sv
`timescale 1ns/1ps

module matmul_accel (
    input  logic                clk,
    input  logic                reset,

    // Host register port
    input  matmul_pkg::word_t   mmio_addr,
    input  matmul_pkg::word_t   mmio_wdata,
    input  logic [3:0]          mmio_we,
    input  logic                mmio_re,
    output matmul_pkg::word_t   mmio_rdata,

    // DMA read port, data returns one cycle after dma_re
    output matmul_pkg::word_t   dma_addr,
    output logic                dma_re,
    input  matmul_pkg::block_t  dma_rdata,

    output logic                accel_busy
);
    import matmul_pkg::*;

    // Command from the register file
    logic                   start;
    word_t                  w_addr;
    word_t                  x_addr;
    dim_t                   m_dim;
    dim_t                   n_dim;
    word_t                  k_dim;

    // Completion back to the register file
    logic                   cmd_done;
    acc_t [TILE*TILE-1:0]   results;

    // Block handover, fetcher to MAC array
    logic                   blk_req;
    logic                   blk_ack;
    block_t                 blk_a;
    block_t                 blk_b;
    kcnt_t                  blk_steps;
    logic                   blk_last;

    mmio_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .mmio_addr  (mmio_addr),
        .mmio_wdata (mmio_wdata),
        .mmio_we    (mmio_we),
        .mmio_re    (mmio_re),
        .mmio_rdata (mmio_rdata),
        .cmd_done   (cmd_done),
        .results    (results),
        .start      (start),
        .w_addr     (w_addr),
        .x_addr     (x_addr),
        .m_dim      (m_dim),
        .n_dim      (n_dim),
        .k_dim      (k_dim),
        .busy       (accel_busy)
    );

    block_fetch u_fetch (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .w_addr     (w_addr),
        .x_addr     (x_addr),
        .k_dim      (k_dim),
        .dma_addr   (dma_addr),
        .dma_re     (dma_re),
        .dma_rdata  (dma_rdata),
        .blk_req    (blk_req),
        .blk_a      (blk_a),
        .blk_b      (blk_b),
        .blk_steps  (blk_steps),
        .blk_last   (blk_last),
        .blk_ack    (blk_ack)
    );

    mac_array u_mac (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .m_dim      (m_dim),
        .n_dim      (n_dim),
        .blk_req    (blk_req),
        .blk_a      (blk_a),
        .blk_b      (blk_b),
        .blk_steps  (blk_steps),
        .blk_last   (blk_last),
        .blk_ack    (blk_ack),
        .cmd_done   (cmd_done),
        .results    (results)
    );

endmodule

// File: tb/matmul_accel_chk.sv
`timescale 1ns/1ps

module matmul_accel_chk (
    input logic                clk,
    input logic                reset,
    input logic                dma_re,
    input logic                accel_busy,
    input logic                start,
    input logic                cmd_done,
    input logic                blk_req,
    input logic                blk_ack,
    input matmul_pkg::block_t  blk_a,
    input matmul_pkg::block_t  blk_b,
    input matmul_pkg::kcnt_t   blk_steps,
    input logic                blk_last
);

    // Count of failed properties
    int fail_cnt = 0;

    // ========================================================================
    // DMA port and handover protocol
    // ========================================================================

    // At most one DMA response in flight
    a_dma_single: assert property (@(posedge clk) disable iff (reset)
        dma_re |=> !dma_re)
    else begin
        $error("dma_re raised while a DMA response was outstanding");
        fail_cnt++;
    end

    a_blk_stable: assert property (@(posedge clk) disable iff (reset)
        (blk_req && $past(blk_req)) |-> $stable({blk_a, blk_b, blk_steps, blk_last}))
    else begin
        $error("block data changed while blk_req was high");
        fail_cnt++;
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        (!blk_req && !blk_ack) |=> !blk_ack)
    else begin
        $error("blk_ack rose without blk_req");
        fail_cnt++;
    end

    // ========================================================================
    // Command status
    // ========================================================================

    a_busy_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(accel_busy) |-> $past(cmd_done))
    else begin
        $error("accel_busy fell without cmd_done in the cycle before");
        fail_cnt++;
    end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !(accel_busy || dma_re || blk_req || blk_ack || start || cmd_done))
    else begin
        $error("control outputs not quiet after reset");
        fail_cnt++;
    end

endmodule

bind matmul_accel matmul_accel_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .dma_re     (dma_re),
    .accel_busy (accel_busy),
    .start      (start),
    .cmd_done   (cmd_done),
    .blk_req    (blk_req),
    .blk_ack    (blk_ack),
    .blk_a      (blk_a),
    .blk_b      (blk_b),
    .blk_steps  (blk_steps),
    .blk_last   (blk_last)
);

// File: tb/tb_matmul_accel.sv
`timescale 1ns/1ps

module tb_matmul_accel;
    import matmul_pkg::*;

    logic       clk = 1'b0;
    logic       reset;
    word_t      mmio_addr;
    word_t      mmio_wdata;
    logic [3:0] mmio_we;
    logic       mmio_re;
    word_t      mmio_rdata;
    word_t      dma_addr;
    logic       dma_re;
    block_t     dma_rdata = '0;
    logic       accel_busy;

    // Operands are wider than any K used so the last block has real bytes past K
    byte    a_mat [4][8];
    byte    b_mat [8][4];
    word_t  x_base = '0;
    word_t  w_base = '0;
    integer seed;
    int     errors = 0;
    logic   waiting = 1'b0;
    int     wait_limit = 0;
    int     wait_cycles = 0;
    logic   dma_pend = 1'b0;
    word_t  dma_pend_addr = '0;

    always #4 clk = ~clk;

    matmul_accel u_dut (
        .clk        (clk),
        .reset      (reset),
        .mmio_addr  (mmio_addr),
        .mmio_wdata (mmio_wdata),
        .mmio_we    (mmio_we),
        .mmio_re    (mmio_re),
        .mmio_rdata (mmio_rdata),
        .dma_addr   (dma_addr),
        .dma_re     (dma_re),
        .dma_rdata  (dma_rdata),
        .accel_busy (accel_busy)
    );

    // ========================================================================
    // DMA memory model
    // ========================================================================

    function automatic block_t dma_block(input word_t addr);
        block_t blk;
        word_t  off_a;
        word_t  off_w;
        int     b;
        off_a = addr - x_base;
        off_w = addr - w_base;
        b = (off_a < 32'd32) ? int'(off_a[4]) : int'(off_w[4]);
        for (int s = 0; s < 4; s++) begin
            for (int l = 0; l < 4; l++) begin
                if (off_a < 32'd32) begin
                    blk[(s*4 + l)*8 +: 8] = a_mat[l][b*4 + s];
                end else if (off_w < 32'd32) begin
                    blk[(s*4 + l)*8 +: 8] = b_mat[b*4 + s][l];
                end else begin
                    blk[(s*4 + l)*8 +: 8] = addr[7:0] ^ addr[15:8] ^ addr[23:16]
                                          ^ addr[31:24] ^ 8'(s*4 + l);
                end
            end
        end
        return blk;
    endfunction

    // Request seen in one cycle, data driven only in the next one
    always @(negedge clk) begin
        dma_pend      <= dma_re;
        dma_pend_addr <= dma_addr;
        if (dma_pend) begin
            dma_rdata <= dma_block(dma_pend_addr);
        end else begin
            dma_rdata <= '0;
        end
    end

    always @(negedge clk) begin
        if (!waiting) begin
            wait_cycles <= 0;
        end else if (wait_cycles >= wait_limit) begin
            $display("Timeout: accel_busy still high after %0d cycles", wait_cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            wait_cycles <= wait_cycles + 1;
        end
    end

    // ========================================================================
    // Host tasks and reference model
    // ========================================================================

    task automatic check(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic write_reg(input logic [7:0] off, input word_t data);
        mmio_addr  = {24'd0, off};
        mmio_wdata = data;
        mmio_we    = 4'hf;
        @(negedge clk);
        mmio_we    = 4'h0;
    endtask

    task automatic read_reg(input logic [7:0] off, output word_t data);
        mmio_addr = {24'd0, off};
        mmio_re   = 1'b1;
        @(negedge clk);
        mmio_re   = 1'b0;
        data      = mmio_rdata;
    endtask

    task automatic fill_operands();
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 8; k++) begin
                a_mat[i][k] = byte'($random(seed));
                b_mat[k][i] = byte'($random(seed));
            end
        end
    endtask

    function automatic word_t ref_result(input int i, input int j, input word_t m,
                                         input word_t n, input word_t k);
        int acc;
        acc = 0;
        if ((i < int'(m)) && (j < int'(n))) begin
            for (int s = 0; s < int'(k); s++) begin
                acc += int'(a_mat[i][s]) * int'(b_mat[s][j]);
            end
        end
        return word_t'(acc);
    endfunction

    task automatic start_command(input word_t m, input word_t n, input word_t k,
                                 input word_t xb, input word_t wb);
        x_base = xb;
        w_base = wb;
        write_reg(REG_W_ADDR, wb);
        write_reg(REG_X_ADDR, xb);
        write_reg(REG_M_DIM, m);
        write_reg(REG_N_DIM, n);
        write_reg(REG_K_DIM, k);
        write_reg(REG_CTRL, 32'h1);
    endtask

    task automatic wait_idle(input int k);
        wait_limit = 40 * ((k + 3) / 4) + 200;
        waiting = 1'b1;
        while (accel_busy) @(negedge clk);
        waiting = 1'b0;
    endtask

    task automatic check_results(input string name, input word_t m, input word_t n,
                                 input word_t k);
        word_t got;
        for (int idx = 0; idx < 16; idx++) begin
            read_reg(REG_RESULT_BASE + 8'(4*idx), got);
            check($sformatf("%s r%0d%0d", name, idx/4, idx%4),
                  ref_result(idx/4, idx%4, m, n, k), got);
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        word_t rd;
        seed       = 32'h86b68efb;
        reset      = 1'b1;
        mmio_addr  = '0;
        mmio_wdata = '0;
        mmio_we    = 4'h0;
        mmio_re    = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        read_reg(REG_CTRL, rd);
        check("reset_status", 32'h2, rd);
        repeat (4) begin
            check("reset_dma_re", 32'h0, {31'd0, dma_re});
            @(negedge clk);
        end

        fill_operands();
        start_command(32'd4, 32'd4, 32'd8, 32'h1000, 32'h2000);
        wait_idle(8);
        check_results("full_4x4_k8", 32'd4, 32'd4, 32'd8);

        // Bytes past K and outside 2x3 are random and must not leak in
        fill_operands();
        start_command(32'd2, 32'd3, 32'd5, 32'h3040, 32'h5080);
        wait_idle(5);
        check_results("masked_2x3_k5", 32'd2, 32'd3, 32'd5);

        // Second start lands while the first command runs
        fill_operands();
        start_command(32'd3, 32'd4, 32'd6, 32'h0400, 32'h0800);
        write_reg(REG_CTRL, 32'h1);
        read_reg(REG_CTRL, rd);
        check("busy_status", 32'h11, rd);
        wait_idle(6);
        check_results("busy_start", 32'd3, 32'd4, 32'd6);
        read_reg(REG_CTRL, rd);
        check("busy_start_error", 32'h12, rd);
        write_reg(REG_CTRL, 32'h10);
        read_reg(REG_CTRL, rd);
        check("busy_error_clear", 32'h2, rd);

        write_reg(REG_K_DIM, 32'd0);
        write_reg(REG_CTRL, 32'h1);
        read_reg(REG_CTRL, rd);
        check("k_zero_error", 32'h12, rd);
        check_results("k_zero_keep", 32'd3, 32'd4, 32'd6);
        write_reg(REG_CTRL, 32'h10);
        read_reg(REG_CTRL, rd);
        check("k_zero_clear", 32'h2, rd);

        fill_operands();
        start_command(32'd4, 32'd4, 32'd4, 32'h6000, 32'h7000);
        wait_idle(4);
        check_results("b2b_first", 32'd4, 32'd4, 32'd4);
        fill_operands();
        start_command(32'd4, 32'd2, 32'd7, 32'h6000, 32'h7000);
        wait_idle(7);
        check_results("b2b_second", 32'd4, 32'd2, 32'd7);

        $display("Errors: %0d testbench checks, %0d assertions",
                 errors, u_dut.u_chk.fail_cnt);
        if ((errors == 0) && (u_dut.u_chk.fail_cnt == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: matmul_accel.f
common/matmul_pkg.sv
verilog/mmio_regs.sv
fetch/block_fetch.sv
mac/mac_array.sv
verilog/matmul_accel.sv
tb/matmul_accel_chk.sv
tb/tb_matmul_accel.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the matmul_accel testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_matmul_accel \
    -f matmul_accel.f \
    --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** TEST FAILED ***' "$LOG"; then
    exit 1
fi
exit 0
